// ==== tb/bru_trace.txt ====
// test op pc pred_pc imm20 a b dest_pr rob_index | wb_valid wb_data notif_valid
// is_taken is_mispredict is_out_of_range start_pc target_pc (all hex)
01 8 00001000 00001040 00040 00000005 00000005 11 01 0 00000000 1 1 0 0 00001002 00001040
02 8 00001000 00001040 00040 00000005 00000006 12 02 0 00000000 1 0 1 0 00001002 00001004
03 9 00002000 00001ff0 00ff1 00000001 00000002 13 03 0 00000000 1 1 0 0 00002002 00001ff0
04 9 00002000 00002004 00ff1 00000007 00000007 14 04 0 00000000 1 0 0 0 00002002 00002004
05 a 00003000 00003002 00040 00000000 00000000 15 05 0 00000000 1 1 1 0 00003000 00003040
06 a 00003000 00003004 00040 00000003 00000000 16 06 0 00000000 1 0 0 0 00003000 00003004
07 b 00003100 00003140 00040 80000000 00000000 17 07 0 00000000 1 1 0 0 00003100 00003140
08 b 00003100 00003140 00040 00000000 00000000 18 08 0 00000000 1 0 1 0 00003100 00003104
09 c 00004000 00004040 00040 ffffffff 00000001 19 09 0 00000000 1 1 0 0 00004002 00004040
0a c 00004000 00004004 00040 00000001 ffffffff 1a 0a 0 00000000 1 0 0 0 00004002 00004004
0b d 00004100 00000000 00040 00000001 80000000 1b 0b 0 00000000 1 1 1 0 00004102 00004140
0c d 00004100 00004104 00040 80000000 00000001 1c 0c 0 00000000 1 0 0 0 00004102 00004104
0d e 00005000 00005040 00040 00000001 80000000 1d 0d 0 00000000 1 1 0 0 00005002 00005040
0e e 00005000 00005004 00040 ffffffff 00000001 1e 0e 0 00000000 1 0 0 0 00005002 00005004
0f f 00005100 00005140 00040 ffffffff 00000001 1f 0f 0 00000000 1 1 0 0 00005102 00005140
10 f 00005100 00005104 00040 00000001 ffffffff 20 10 0 00000000 1 0 0 0 00005102 00005104
11 c 00003ff0 00004030 00040 fffffffe 00000007 21 11 0 00000000 1 1 0 1 00003ff2 00004030
12 0 00006000 00008010 00010 00008000 00000000 22 12 1 00006004 1 1 0 1 00006002 00008010
13 0 00006200 00000000 00ffc 00006100 00000000 23 13 1 00006204 1 1 1 0 00006202 000060fc
14 1 00006300 00007000 00000 00007000 00000000 24 14 1 00006302 1 1 0 0 00006300 00007000
15 2 00006400 00018744 12344 00000000 00000000 25 15 1 00006404 1 1 0 1 00006402 00018744
16 3 00006500 00006500 00040 00000000 00000000 26 16 1 00006502 1 1 1 0 00006500 00006540
17 4 00006600 000065e0 fffe1 00000000 00000000 27 17 0 00000000 1 1 0 0 00006600 000065e0
18 5 00006700 12345678 00000 12345678 00000000 28 18 0 00000000 1 1 0 1 00006700 12345678
19 6 00006800 00000000 deabc 00000000 00000000 29 19 1 abcde000 0 0 0 0 00000000 00000000
1a 7 00006800 00000000 01000 00000000 00000000 2a 1a 1 00007800 0 0 0 0 00000000 00000000

// ==== src.f ====
rtl/bru_isa_pkg.sv
rtl/bru_core_pkg.sv
rtl/bru_imm_expand.sv
rtl/bru_issue_stage.sv
rtl/bru_resolve.sv
rtl/bru_writeback.sv
rtl/bru_pipeline.sv
tb/tb_bru_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the BRU pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_bru_pipeline -o sim_bru
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bru > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb/tb_bru_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_bru_pipeline import bru_isa_pkg::*, bru_core_pkg::*;;

    localparam int N_TESTS  = 26;
    localparam int N_FIELDS = 17;
    localparam int LIMIT    = 20 * N_TESTS + 50;   // cycles before the run is abandoned

    // column positions inside one trace record
    localparam int F_TEST   = 0;
    localparam int F_OP     = 1;
    localparam int F_PC     = 2;
    localparam int F_PRED   = 3;
    localparam int F_IMM    = 4;
    localparam int F_A      = 5;
    localparam int F_B      = 6;
    localparam int F_PR     = 7;
    localparam int F_ROB    = 8;
    localparam int F_WBV    = 9;
    localparam int F_WBD    = 10;
    localparam int F_NV     = 11;
    localparam int F_TAKEN  = 12;
    localparam int F_MIS    = 13;
    localparam int F_OOR    = 14;
    localparam int F_START  = 15;
    localparam int F_TARGET = 16;

    logic       CLK;
    logic       nRST;
    logic       issue_valid;
    bru_issue_t issue;
    logic       issue_ready;
    logic       wb_valid;
    bru_wb_t    wb;
    logic       wb_ready;
    logic       notif_valid;
    bru_notif_t notif;
    logic       notif_ready;

    logic [31:0] trace_mem [N_TESTS * N_FIELDS];
    int          wb_q[$];      // record indices still owed a writeback
    int          notif_q[$];   // record indices still owed a notification
    int          pend [N_TESTS];
    bit          test_err [N_TESTS];
    int          errors;
    int          finished;
    int          cycles;
    int          seed;
    bit          rand_en;
    bit          hold_wb;
    bit          hold_notif;
    bru_wb_t     held_wb;
    bru_notif_t  held_notif;

    bru_pipeline #(
        .UPPER_PC_WIDTH (18)
    ) i_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready),
        .notif_valid (notif_valid),
        .notif       (notif),
        .notif_ready (notif_ready)
    );

    always #10 CLK = ~CLK;

    // --------------------------------------------------------------------------
    // helpers

    function automatic logic [31:0] field(input int idx, input int f);
        return trace_mem[idx * N_FIELDS + f];
    endfunction

    function automatic string test_name(input int idx);
        logic [31:0] w;
        bru_op_e     op;
        w  = field(idx, F_OP);
        op = bru_op_e'(w[3:0]);
        return $sformatf("t%0d_%s", field(idx, F_TEST), op.name());
    endfunction

    task automatic compare_field(input int idx, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("MISMATCH %s %s expected %h actual %h", test_name(idx), what, exp, act);
            errors++;
            test_err[idx] = 1'b1;
        end
    endtask

    task automatic finish_test(input int idx);
        pend[idx]--;
        if (pend[idx] == 0) begin
            finished++;
            $display("test %s %s", test_name(idx), test_err[idx] ? "FAILED" : "ok");
        end
    endtask

    task automatic load_issue(input int idx);
        logic [31:0] w;
        w = field(idx, F_OP);
        issue.op = bru_op_e'(w[3:0]);
        issue.pc      = field(idx, F_PC);
        issue.pred_pc = field(idx, F_PRED);
        w = field(idx, F_IMM);
        issue.imm20 = w[19:0];
        issue.a     = field(idx, F_A);
        issue.b     = field(idx, F_B);
        w = field(idx, F_PR);
        issue.dest_pr = w[6:0];
        w = field(idx, F_ROB);
        issue.rob_index = w[6:0];
    endtask

    // queue the channel events an accepted op owes
    task automatic expect_op(input int idx);
        logic [31:0] wv;
        logic [31:0] nv;
        wv = field(idx, F_WBV);
        nv = field(idx, F_NV);
        if (wv[0]) wb_q.push_back(idx);
        if (nv[0]) notif_q.push_back(idx);
        pend[idx] = int'(wv[0]) + int'(nv[0]);
    endtask

    task automatic step_cycle();
        @(negedge CLK);
        if (rand_en) begin
            wb_ready    = ($random(seed) & 3) != 0;   // ready about 3 cycles in 4
            notif_ready = ($random(seed) & 3) != 0;
        end
    endtask

    task automatic issue_op(input int idx);
        logic accepted;
        load_issue(idx);
        issue_valid = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(posedge CLK);
            accepted = issue_ready;
            if (accepted) expect_op(idx);
            step_cycle();
        end
        issue_valid = 1'b0;
    endtask

    // --------------------------------------------------------------------------
    // timeout

    always @(posedge CLK) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d tests finished",
                     cycles, finished, N_TESTS);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------------------------------------------------------------
    // output monitor, sampled before the edge updates the DUT

    always @(posedge CLK) begin
        int idx;
        if (nRST) begin
            if (hold_wb) begin
                assert (wb_valid && wb == held_wb) else begin
                    $display("writeback output changed while held by back-pressure");
                    errors++;
                end
            end
            if (hold_notif) begin
                assert (notif_valid && notif == held_notif) else begin
                    $display("notification output changed while held by back-pressure");
                    errors++;
                end
            end
            hold_wb    = wb_valid && !wb_ready;
            held_wb    = wb;
            hold_notif = notif_valid && !notif_ready;
            held_notif = notif;

            if (wb_valid && wb_ready) begin
                assert (wb_q.size() > 0) else begin
                    $display("writeback transfer with no op outstanding");
                    errors++;
                end
                if (wb_q.size() > 0) begin
                    idx = wb_q.pop_front();
                    compare_field(idx, "wb_data", field(idx, F_WBD), wb.data);
                    compare_field(idx, "wb_pr", field(idx, F_PR), 32'(wb.pr));
                    compare_field(idx, "wb_rob", field(idx, F_ROB), 32'(wb.rob_index));
                    finish_test(idx);
                end
            end

            if (notif_valid && notif_ready) begin
                assert (notif_q.size() > 0) else begin
                    $display("notification transfer with no op outstanding");
                    errors++;
                end
                if (notif_q.size() > 0) begin
                    idx = notif_q.pop_front();
                    compare_field(idx, "rob_index", field(idx, F_ROB), 32'(notif.rob_index));
                    compare_field(idx, "is_taken", field(idx, F_TAKEN), 32'(notif.is_taken));
                    compare_field(idx, "is_mispredict", field(idx, F_MIS),
                                  32'(notif.is_mispredict));
                    compare_field(idx, "is_out_of_range", field(idx, F_OOR),
                                  32'(notif.is_out_of_range));
                    compare_field(idx, "start_pc", field(idx, F_START), notif.start_pc);
                    compare_field(idx, "target_pc", field(idx, F_TARGET), notif.target_pc);
                    finish_test(idx);
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // stimulus

    initial begin
        int lat;
        seed        = 58356;
        errors      = 0;
        finished    = 0;
        cycles      = 0;
        rand_en     = 1'b0;
        hold_wb     = 1'b0;
        hold_notif  = 1'b0;
        CLK         = 1'b0;
        nRST        = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        wb_ready    = 1'b1;
        notif_ready = 1'b1;

        $readmemh("tb/bru_trace.txt", trace_mem);
        for (int i = 0; i < N_TESTS; i++) begin
            pend[i]     = 0;
            test_err[i] = 1'b0;
            assert (field(i, F_TEST) == i + 1) else begin
                $display("trace record %0d holds test number %0d", i, field(i, F_TEST));
                errors++;
            end
        end

        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        assert (!wb_valid && !notif_valid && issue_ready) else begin
            $display("outputs not idle after reset");
            errors++;
        end

        // first op alone with both channels open, 3 cycle latency
        issue_op(0);
        lat = 0;
        while (!notif_valid && lat < 8) begin
            @(negedge CLK);
            lat++;
        end
        compare_field(0, "latency", 32'd3, 32'(lat));

        rand_en = 1'b1;
        for (int i = 1; i < N_TESTS; i++) begin
            while (($random(seed) & 7) == 0) step_cycle();   // occasional bubble
            issue_op(i);
        end
        while (finished < N_TESTS) step_cycle();

        // both channels open, so any stray event still gets through
        rand_en     = 1'b0;
        wb_ready    = 1'b1;
        notif_ready = 1'b1;
        repeat (4) step_cycle();

        $display("tests finished %0d of %0d, errors %0d", finished, N_TESTS, errors);
        if (errors == 0 && wb_q.size() == 0 && notif_q.size() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/bru_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ns

module bru_pipeline import bru_core_pkg::*; #(
    parameter int UPPER_PC_WIDTH = 18
) (
    input  logic       CLK,
    input  logic       nRST,

    // issue from BRU issue queue
    input  logic       issue_valid,
    input  bru_issue_t issue,
    output logic       issue_ready,

    // register writeback
    output logic       wb_valid,
    output bru_wb_t    wb,
    input  logic       wb_ready,

    // branch notification to ROB
    output logic       notif_valid,
    output bru_notif_t notif,
    input  logic       notif_ready
);

    logic     ex_valid;
    bru_ex_t  ex;
    logic     ex_ready;

    logic     res_valid;
    bru_res_t res;
    logic     res_ready;

    bru_issue_stage i_issue (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .ex_valid    (ex_valid),
        .ex          (ex),
        .ex_ready    (ex_ready)
    );

    bru_resolve i_resolve (
        .CLK       (CLK),
        .nRST      (nRST),
        .ex_valid  (ex_valid),
        .ex        (ex),
        .ex_ready  (ex_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    bru_writeback #(
        .UPPER_PC_WIDTH (UPPER_PC_WIDTH)
    ) i_writeback (
        .CLK         (CLK),
        .nRST        (nRST),
        .res_valid   (res_valid),
        .res         (res),
        .res_ready   (res_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready),
        .notif_valid (notif_valid),
        .notif       (notif),
        .notif_ready (notif_ready)
    );

endmodule

`default_nettype wire

// ==== rtl/bru_writeback.sv ====
`default_nettype none
`timescale 1ns/1ns

module bru_writeback import bru_isa_pkg::*, bru_core_pkg::*; #(
    parameter int UPPER_PC_WIDTH = 18   // PC bits above what the BTB keeps
) (
    input  logic       CLK,
    input  logic       nRST,

    // from EX1
    input  logic       res_valid,
    input  bru_res_t   res,
    output logic       res_ready,

    // register writeback
    output logic       wb_valid,
    output bru_wb_t    wb,
    input  logic       wb_ready,

    // branch notification to ROB
    output logic       notif_valid,
    output bru_notif_t notif,
    input  logic       notif_ready
);

    logic     ex2_valid;
    bru_res_t ex2_q;

    logic       stall_out;
    logic       next_wb_valid;
    logic       next_notif_valid;
    bru_wb_t    next_wb;
    bru_notif_t next_notif;

    // either channel holding freezes the output stage
    assign stall_out = (wb_valid & ~wb_ready) | (notif_valid & ~notif_ready);

    assign res_ready = ~ex2_valid | ~stall_out;

    // ------------------------------------------------------------------------
    // EX2 register and flags

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            ex2_valid <= 1'b0;
        end else if (res_ready) begin
            ex2_valid <= res_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (res_valid & res_ready) begin
            ex2_q <= res;
        end
    end

    assign next_wb_valid    = ex2_valid & writes_reg(ex2_q.op);
    assign next_notif_valid = ex2_valid & notifies(ex2_q.op);

    always_comb begin
        next_wb.data      = ex2_q.write_data;
        next_wb.pr        = ex2_q.dest_pr;
        next_wb.rob_index = ex2_q.rob_index;

        next_notif.rob_index     = ex2_q.rob_index;
        next_notif.is_mispredict = ex2_q.target_pc != ex2_q.pred_pc;
        next_notif.is_taken      = ex2_q.is_taken;
        // target leaves the region the BTB can encode
        next_notif.is_out_of_range = ex2_q.target_pc[31 -: UPPER_PC_WIDTH]
                                  != ex2_q.start_pc[31 -: UPPER_PC_WIDTH];
        next_notif.start_pc  = ex2_q.start_pc;
        next_notif.target_pc = ex2_q.target_pc;
    end

    // ------------------------------------------------------------------------
    // output registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            wb_valid    <= 1'b0;
            notif_valid <= 1'b0;
        end else if (stall_out) begin
            // a channel that got through drops out, the other keeps holding
            wb_valid    <= wb_valid & ~wb_ready;
            notif_valid <= notif_valid & ~notif_ready;
        end else begin
            wb_valid    <= next_wb_valid;
            notif_valid <= next_notif_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_out & next_wb_valid) begin
            wb <= next_wb;
        end
        if (~stall_out & next_notif_valid) begin
            notif <= next_notif;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bru_resolve.sv ====
`default_nettype none
`timescale 1ns/1ns

module bru_resolve import bru_isa_pkg::*, bru_core_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,

    // from issue capture
    input  logic     ex_valid,
    input  bru_ex_t  ex,
    output logic     ex_ready,

    // toward EX2
    output logic     res_valid,
    output bru_res_t res,
    input  logic     res_ready
);

    logic    ex1_valid;
    bru_ex_t ex1_q;

    word_t pc_plus_imm;
    word_t pc_plus_2;
    word_t pc_plus_4;
    word_t a_plus_imm;
    logic  low_lt;     // a[30:0] < b[30:0], shared by both compares
    logic  a_eq_b;
    logic  a_eq_zero;
    logic  a_lts_b;
    logic  a_ltu_b;
    logic  cond_met;

    // ------------------------------------------------------------------------
    // EX1 register

    assign ex_ready = ~ex1_valid | res_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            ex1_valid <= 1'b0;
        end else if (ex_ready) begin
            ex1_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (ex_valid & ex_ready) begin
            ex1_q <= ex;
        end
    end

    assign res_valid = ex1_valid;

    // ------------------------------------------------------------------------
    // adders and comparators

    assign pc_plus_imm = ex1_q.pc + ex1_q.imm32;
    assign pc_plus_2   = ex1_q.pc + 32'd2;
    assign pc_plus_4   = ex1_q.pc + 32'd4;
    assign a_plus_imm  = ex1_q.a + ex1_q.imm32;

    assign low_lt    = ex1_q.a[30:0] < ex1_q.b[30:0];
    assign a_eq_b    = ex1_q.a == ex1_q.b;
    assign a_eq_zero = ex1_q.a == 32'h0;

    // sign bits decide unless equal, then the low bits do
    assign a_lts_b = (ex1_q.a[31] & ~ex1_q.b[31])
                   | ((ex1_q.a[31] == ex1_q.b[31]) & low_lt);
    assign a_ltu_b = (~ex1_q.a[31] & ex1_q.b[31])
                   | ((ex1_q.a[31] == ex1_q.b[31]) & low_lt);

    always_comb begin
        case (ex1_q.op)
            BRU_BEQ:    cond_met = a_eq_b;
            BRU_BNE:    cond_met = ~a_eq_b;
            BRU_C_BEQZ: cond_met = a_eq_zero;
            BRU_C_BNEZ: cond_met = ~a_eq_zero;
            BRU_BLT:    cond_met = a_lts_b;
            BRU_BGE:    cond_met = ~a_lts_b;
            BRU_BLTU:   cond_met = a_ltu_b;
            BRU_BGEU:   cond_met = ~a_ltu_b;
            default:    cond_met = 1'b1;   // jumps always go
        endcase
    end

    // ------------------------------------------------------------------------
    // op-wise target, start PC and link value

    always_comb begin
        res.op        = ex1_q.op;
        res.pred_pc   = ex1_q.pred_pc;
        res.dest_pr   = ex1_q.dest_pr;
        res.rob_index = ex1_q.rob_index;

        res.is_taken   = cond_met;
        res.target_pc  = pc_plus_imm;
        res.start_pc   = pc_plus_2;    // 4-byte ops
        res.write_data = pc_plus_4;

        if (is_conditional(ex1_q.op)) begin
            res.target_pc = cond_met ? pc_plus_imm : pc_plus_4;
        end

        case (ex1_q.op)
            BRU_JALR: begin
                res.target_pc = a_plus_imm;
            end
            BRU_C_JALR: begin
                res.target_pc  = ex1_q.a;
                res.start_pc   = ex1_q.pc;
                res.write_data = pc_plus_2;
            end
            BRU_C_JAL: begin
                res.start_pc   = ex1_q.pc;
                res.write_data = pc_plus_2;
            end
            BRU_C_J: res.start_pc = ex1_q.pc;
            BRU_C_JR: begin
                res.target_pc = ex1_q.a;
                res.start_pc  = ex1_q.pc;
            end
            BRU_LUI: begin
                res.is_taken   = 1'b0;
                res.write_data = ex1_q.imm32;
            end
            BRU_AUIPC: begin
                res.is_taken   = 1'b0;
                res.write_data = pc_plus_imm;
            end
            BRU_C_BEQZ, BRU_C_BNEZ: res.start_pc = ex1_q.pc;
            default: ;   // JAL and 4-byte branches keep the defaults
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/bru_issue_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

module bru_issue_stage import bru_isa_pkg::*, bru_core_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,

    // from issue queue
    input  logic       issue_valid,
    input  bru_issue_t issue,
    output logic       issue_ready,

    // toward EX1
    output logic       ex_valid,
    output bru_ex_t    ex,
    input  logic       ex_ready
);

    logic       valid_q;   // capture register occupied
    bru_issue_t issue_q;
    word_t      imm32;

    // ------------------------------------------------------------------------
    // capture register

    assign issue_ready = ~valid_q | ex_ready;   // empty, or content leaving now

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_q <= 1'b0;
        end else if (issue_ready) begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid & issue_ready) begin
            issue_q <= issue;
        end
    end

    // ------------------------------------------------------------------------
    // immediate expansion and EX1 payload

    bru_imm_expand i_imm_expand (
        .op    (issue_q.op),
        .imm20 (issue_q.imm20),
        .imm32 (imm32)
    );

    assign ex_valid = valid_q;

    always_comb begin
        ex.op        = issue_q.op;
        ex.pc        = issue_q.pc;
        ex.pred_pc   = issue_q.pred_pc;
        ex.imm32     = imm32;
        ex.a         = issue_q.a;
        ex.b         = issue_q.b;
        ex.dest_pr   = issue_q.dest_pr;
        ex.rob_index = issue_q.rob_index;
    end

endmodule

`default_nettype wire

// ==== rtl/bru_imm_expand.sv ====
`default_nettype none
`timescale 1ns/1ns

module bru_imm_expand import bru_isa_pkg::*; (
    input  bru_op_e op,
    input  imm20_t  imm20,
    output word_t   imm32
);

    logic  sign;
    word_t imm_i;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign sign = imm20[11];   // same position for every format

    // I: plain 12-bit sign extension
    assign imm_i = {{20{sign}}, imm20[11:0]};

    // B: bit 11 of the offset is carried in imm20[0]
    assign imm_b = {{20{sign}}, imm20[0], imm20[10:1], 1'b0};

    // U: upper 20 bits rotated back into place, low 12 zero
    assign imm_u = {sign, imm20[10:0], imm20[19:12], 12'h000};

    // J: like B but with imm20[19:12] filling the middle
    assign imm_j = {{12{sign}}, imm20[19:12], imm20[0], imm20[10:1], 1'b0};

    always_comb begin
        if (op == BRU_JALR) begin
            imm32 = imm_i;
        end else if (op == BRU_LUI || op == BRU_AUIPC) begin
            imm32 = imm_u;
        end else if (is_conditional(op)) begin
            imm32 = imm_b;
        end else begin
            imm32 = imm_j;   // JAL, C.JAL, C.J, C.JALR, C.JR
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bru_core_pkg.sv ====
`default_nettype none

package bru_core_pkg;

    import bru_isa_pkg::*;

    typedef logic [6:0] pr_idx_t;    // physical register index
    typedef logic [6:0] rob_idx_t;   // reorder buffer index

    // payload from the issue queue, operands already read
    typedef struct packed {
        bru_op_e  op;
        word_t    pc;
        word_t    pred_pc;
        imm20_t   imm20;
        word_t    a;
        word_t    b;
        pr_idx_t  dest_pr;
        rob_idx_t rob_index;
    } bru_issue_t;

    // into EX1, immediate expanded
    typedef struct packed {
        bru_op_e  op;
        word_t    pc;
        word_t    pred_pc;
        word_t    imm32;
        word_t    a;
        word_t    b;
        pr_idx_t  dest_pr;
        rob_idx_t rob_index;
    } bru_ex_t;

    // resolved op, into EX2
    typedef struct packed {
        bru_op_e  op;
        logic     is_taken;
        word_t    start_pc;
        word_t    target_pc;
        word_t    pred_pc;
        word_t    write_data;
        pr_idx_t  dest_pr;
        rob_idx_t rob_index;
    } bru_res_t;

    typedef struct packed {
        word_t    data;
        pr_idx_t  pr;
        rob_idx_t rob_index;
    } bru_wb_t;

    typedef struct packed {
        rob_idx_t rob_index;
        logic     is_mispredict;
        logic     is_taken;
        logic     is_out_of_range;
        word_t    start_pc;
        word_t    target_pc;
    } bru_notif_t;

endpackage

`default_nettype wire

// ==== rtl/bru_isa_pkg.sv ====
`default_nettype none

package bru_isa_pkg;

    typedef logic [31:0] word_t;     // data word or PC
    typedef logic [19:0] imm20_t;    // packed immediate, sign always in bit 11

    // op codes as issued by the BRU issue queue
    typedef enum logic [3:0] {
        BRU_JALR   = 4'b0000,
        BRU_C_JALR = 4'b0001,
        BRU_JAL    = 4'b0010,
        BRU_C_JAL  = 4'b0011,
        BRU_C_J    = 4'b0100,
        BRU_C_JR   = 4'b0101,
        BRU_LUI    = 4'b0110,
        BRU_AUIPC  = 4'b0111,
        BRU_BEQ    = 4'b1000,
        BRU_BNE    = 4'b1001,
        BRU_C_BEQZ = 4'b1010,
        BRU_C_BNEZ = 4'b1011,
        BRU_BLT    = 4'b1100,
        BRU_BGE    = 4'b1101,
        BRU_BLTU   = 4'b1110,
        BRU_BGEU   = 4'b1111
    } bru_op_e;

    // conditional branches occupy the upper half of the code space
    function automatic logic is_conditional(input bru_op_e op);
        return op >= BRU_BEQ;
    endfunction

    // link jumps and upper-immediate ops produce a register result
    function automatic logic writes_reg(input bru_op_e op);
        return op inside {BRU_JALR, BRU_C_JALR, BRU_JAL, BRU_C_JAL, BRU_LUI, BRU_AUIPC};
    endfunction

    // everything but LUI/AUIPC reports to the ROB
    function automatic logic notifies(input bru_op_e op);
        return !(op inside {BRU_LUI, BRU_AUIPC});
    endfunction

endpackage

`default_nettype wire
